// File: src/capture_pkg.sv
package capture_pkg;

   // Sample and source tag widths
   localparam int DATA_W = 16;
   localparam int TAG_W  = 2;

   // One FIFO entry, tag on top of the sample
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] sample;
   } capture_word_t;

   localparam logic [TAG_W-1:0] TAG_TRACE = 2'd1;
   localparam logic [TAG_W-1:0] TAG_LA    = 2'd2;

   // Host register map
   localparam logic [7:0] REG_CTRL_ADDR   = 8'h01;
   localparam logic [7:0] REG_LENGTH_ADDR = 8'h02;
   localparam logic [7:0] REG_STATUS_ADDR = 8'h03;
   localparam logic [7:0] FIFO_READ_ADDR  = 8'h10;  // Byte-wise FIFO drain

   // Control register bits
   localparam int CTRL_ARM_BIT     = 0;
   localparam int CTRL_SRC_BIT     = 1;  // 0 selects trace, 1 selects LA
   localparam int CTRL_CLR_ERR_BIT = 2;
   localparam int CTRL_FLUSH_BIT   = 3;

   // Status register bits
   localparam int STAT_EMPTY_BIT  = 0;
   localparam int STAT_FULL_BIT   = 1;
   localparam int STAT_OVF_BIT    = 2;
   localparam int STAT_ACTIVE_BIT = 3;

endpackage

// File: src/usb_reg_port.sv
`timescale 1ns/100ps

module usb_reg_port import capture_pkg::*; (
   input  logic       clk_usb_buf,
   input  logic       arst_n_i,
   input  logic [7:0] usb_addr_i,
   input  logic [7:0] usb_data_i,
   input  logic       usb_alen_n_i,
   input  logic       usb_cen_n_i,
   input  logic       usb_wrn_n_i,
   input  logic       usb_rdn_n_i,
   input  logic [7:0] reg_rdata_i,
   input  logic [7:0] fifo_byte_i,
   output logic [7:0] usb_data_o,
   output logic       usb_data_oe_o,
   output logic [7:0] reg_addr_o,
   output logic [7:0] reg_wdata_o,
   output logic       reg_write_o,
   output logic       fifo_rd_o
);

   logic wr_lvl;
   logic rd_lvl;
   logic wr_lvl_q;
   logic rd_lvl_q;
   logic reg_read;
   logic fifo_sel;

   // Strobe levels as seen on the bus
   assign wr_lvl = ~usb_cen_n_i & ~usb_wrn_n_i;
   assign rd_lvl = ~usb_cen_n_i & ~usb_rdn_n_i;

   assign usb_data_oe_o = rd_lvl;  // Host reads while both are low
   assign fifo_sel      = (reg_addr_o == FIFO_READ_ADDR);
   assign fifo_rd_o     = reg_read & fifo_sel;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reg_addr_o  <= '0;
         wr_lvl_q    <= 1'b0;
         rd_lvl_q    <= 1'b0;
         reg_write_o <= 1'b0;
         reg_read    <= 1'b0;
         usb_data_o  <= '0;
      end else begin
         if (!usb_alen_n_i)
            reg_addr_o <= usb_addr_i;
         wr_lvl_q    <= wr_lvl;
         rd_lvl_q    <= rd_lvl;
         // First sampled cycle of each strobe
         reg_write_o <= wr_lvl & ~wr_lvl_q;
         reg_read    <= rd_lvl & ~rd_lvl_q;
         if (reg_read) begin
            // FIFO reads skip the register read-back
            usb_data_o <= fifo_sel ? fifo_byte_i : reg_rdata_i;
         end
      end
   end

   // Write data travels with the write pulse
   always_ff @(posedge clk_usb_buf) begin
      if (wr_lvl && !wr_lvl_q)
         reg_wdata_o <= usb_data_i;
   end

endmodule

// File: src/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs import capture_pkg::*; (
   input  logic       clk_usb_buf,
   input  logic       arst_n_i,
   input  logic [7:0] reg_addr_i,
   input  logic [7:0] reg_wdata_i,
   input  logic       reg_write_i,
   input  logic       cap_done_i,
   input  logic       cap_active_i,
   input  logic       fifo_empty_i,
   input  logic       fifo_full_i,
   input  logic       ovf_err_i,
   output logic [7:0] reg_rdata_o,
   output logic       arm_o,
   output logic       src_sel_o,
   output logic [7:0] length_o,
   output logic       clr_err_o,
   output logic       flush_o
);

   logic       ctrl_wr;
   logic       length_wr;
   logic [7:0] ctrl_rd;
   logic [7:0] stat_rd;

   assign ctrl_wr   = reg_write_i & (reg_addr_i == REG_CTRL_ADDR);
   assign length_wr = reg_write_i & (reg_addr_i == REG_LENGTH_ADDR);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         arm_o     <= 1'b0;
         src_sel_o <= 1'b0;
         length_o  <= '0;
         clr_err_o <= 1'b0;
         flush_o   <= 1'b0;
      end else begin
         clr_err_o <= ctrl_wr & reg_wdata_i[CTRL_CLR_ERR_BIT];  // Self-clearing
         flush_o   <= ctrl_wr & reg_wdata_i[CTRL_FLUSH_BIT];
         if (ctrl_wr) begin
            arm_o     <= reg_wdata_i[CTRL_ARM_BIT];
            src_sel_o <= reg_wdata_i[CTRL_SRC_BIT];
         end else if (cap_done_i) begin
            arm_o <= 1'b0;  // Capture finished, disarm
         end
         if (length_wr)
            length_o <= reg_wdata_i;
      end
   end

   // Pulse bits always read back as zero
   always_comb begin
      ctrl_rd                   = '0;
      ctrl_rd[CTRL_ARM_BIT]     = arm_o;
      ctrl_rd[CTRL_SRC_BIT]     = src_sel_o;
      stat_rd                   = '0;
      stat_rd[STAT_EMPTY_BIT]   = fifo_empty_i;
      stat_rd[STAT_FULL_BIT]    = fifo_full_i;
      stat_rd[STAT_OVF_BIT]     = ovf_err_i;
      stat_rd[STAT_ACTIVE_BIT]  = cap_active_i;
      case (reg_addr_i)
         REG_CTRL_ADDR:   reg_rdata_o = ctrl_rd;
         REG_LENGTH_ADDR: reg_rdata_o = length_o;
         REG_STATUS_ADDR: reg_rdata_o = stat_rd;
         default:         reg_rdata_o = '0;
      endcase
   end

endmodule

// File: src/capture_select.sv
`timescale 1ns/100ps

module capture_select import capture_pkg::*; (
   input  logic              clk_usb_buf,
   input  logic              arst_n_i,
   input  logic              arm_i,
   input  logic              src_sel_i,
   input  logic [7:0]        length_i,
   input  logic [DATA_W-1:0] trace_data_i,
   input  logic              trace_valid_i,
   input  logic [DATA_W-1:0] la_data_i,
   input  logic              la_valid_i,
   output logic              wr_en_o,
   output capture_word_t     wr_word_o,
   output logic              cap_done_o,
   output logic              cap_active_o
);

   logic [7:0]    count;
   logic          sel_valid;
   capture_word_t sel_word;
   logic          take;

   always_comb begin
      sel_valid       = src_sel_i ? la_valid_i : trace_valid_i;
      sel_word.sample = src_sel_i ? la_data_i : trace_data_i;
      sel_word.tag    = src_sel_i ? TAG_LA : TAG_TRACE;
   end

   assign cap_active_o = arm_i & (count < length_i);
   assign take         = cap_active_o & sel_valid;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count      <= '0;
         wr_en_o    <= 1'b0;
         cap_done_o <= 1'b0;
      end else begin
         wr_en_o    <= take;
         cap_done_o <= arm_i & ~cap_active_o & ~cap_done_o;  // One pulse per capture
         if (!arm_i)
            count <= '0;
         else if (take)
            count <= count + 8'd1;  // Counted even if the FIFO drops it
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (take)
         wr_word_o <= sel_word;
   end

endmodule

// File: src/capture_fifo.sv
`timescale 1ns/100ps

module capture_fifo import capture_pkg::*; #(
   parameter int pFIFO_DEPTH = 16
) (
   input  logic          clk_usb_buf,
   input  logic          arst_n_i,
   input  logic          wr_en_i,
   input  capture_word_t wr_word_i,
   input  logic          pop_i,
   input  logic          flush_i,
   input  logic          clr_err_i,
   output capture_word_t rd_word_o,
   output logic          empty_o,
   output logic          full_o,
   output logic          ovf_err_o
);

   localparam int AW = $clog2(pFIFO_DEPTH);

   capture_word_t mem [pFIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_wr;
   logic          do_pop;

   assign empty_o   = (count == '0);
   assign full_o    = (count == (AW+1)'(pFIFO_DEPTH));
   assign do_wr     = wr_en_i & ~full_o;   // Writes into a full FIFO are lost
   assign do_pop    = pop_i & ~empty_o;
   assign rd_word_o = mem[rd_ptr];

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         ovf_err_o <= 1'b0;
      end else begin
         if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (do_wr)
               wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
            if (do_pop)
               rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_pop);
         end
         // Sticky until cleared, a new drop wins
         if (wr_en_i && full_o)
            ovf_err_o <= 1'b1;
         else if (clr_err_i)
            ovf_err_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (do_wr)
         mem[wr_ptr] <= wr_word_i;
   end

endmodule

// File: src/fifo_byte_reader.sv
`timescale 1ns/100ps

module fifo_byte_reader import capture_pkg::*; (
   input  logic          clk_usb_buf,
   input  logic          arst_n_i,
   input  logic          fifo_rd_i,
   input  logic          flush_i,
   input  capture_word_t rd_word_i,
   input  logic          empty_i,
   output logic [7:0]    fifo_byte_o,
   output logic          pop_o
);

   logic [1:0] byte_idx;
   logic       advance;

   assign advance = fifo_rd_i & ~empty_i;         // Empty reads leave the index alone
   assign pop_o   = advance & (byte_idx == 2'd2);  // Word done after its third byte

   // Byte order is sample low, sample high, tag
   always_comb begin
      if (empty_i) begin
         fifo_byte_o = '0;
      end else begin
         case (byte_idx)
            2'd0:    fifo_byte_o = rd_word_i.sample[7:0];
            2'd1:    fifo_byte_o = rd_word_i.sample[15:8];
            default: fifo_byte_o = {{(8-TAG_W){1'b0}}, rd_word_i.tag};
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         byte_idx <= 2'd0;
      end else if (flush_i) begin
         byte_idx <= 2'd0;
      end else if (advance) begin
         byte_idx <= (byte_idx == 2'd2) ? 2'd0 : byte_idx + 2'd1;
      end
   end

endmodule

// File: src/led_status.sv
`timescale 1ns/100ps

module led_status #(
   parameter int pFLASH_BITS = 4
) (
   input  logic clk_usb_buf,
   input  logic arst_n_i,
   input  logic err_i,
   input  logic active_i,
   input  logic arm_i,
   output logic led_error_o,
   output logic led_capture_o,
   output logic led_armed_o
);

   logic [pFLASH_BITS-1:0] flash_cnt;  // Free-running

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flash_cnt     <= '0;
         led_error_o   <= 1'b0;
         led_capture_o <= 1'b0;
         led_armed_o   <= 1'b0;
      end else begin
         flash_cnt     <= flash_cnt + 1'b1;
         led_error_o   <= err_i & flash_cnt[pFLASH_BITS-1];  // Blink on error
         led_capture_o <= active_i;
         led_armed_o   <= arm_i;
      end
   end

endmodule

// File: src/capture_usb_top.sv
`timescale 1ns/100ps

module capture_usb_top import capture_pkg::*; #(
   parameter int pFIFO_DEPTH = 16,
   parameter int pFLASH_BITS = 4
) (
   input  logic              clk_usb_buf,
   input  logic              arst_n_i,
   // Host bus
   input  logic [7:0]        usb_addr_i,
   input  logic [7:0]        usb_data_i,
   output logic [7:0]        usb_data_o,
   output logic              usb_data_oe_o,
   input  logic              usb_alen_n_i,
   input  logic              usb_cen_n_i,
   input  logic              usb_wrn_n_i,
   input  logic              usb_rdn_n_i,
   // Capture sources
   input  logic [DATA_W-1:0] trace_data_i,
   input  logic              trace_valid_i,
   input  logic [DATA_W-1:0] la_data_i,
   input  logic              la_valid_i,
   output logic              led_error_o,
   output logic              led_capture_o,
   output logic              led_armed_o
);

   logic [7:0]    reg_addr;
   logic [7:0]    reg_wdata;
   logic          reg_write;
   logic [7:0]    reg_rdata;
   logic          fifo_rd;
   logic [7:0]    fifo_byte;
   logic          arm;
   logic          src_sel;
   logic [7:0]    length;
   logic          clr_err;
   logic          flush;
   logic          cap_done;
   logic          cap_active;
   logic          wr_en;
   capture_word_t wr_word;
   capture_word_t rd_word;
   logic          fifo_empty;
   logic          fifo_full;
   logic          ovf_err;
   logic          pop;

   usb_reg_port u_usb_reg_port (
      .clk_usb_buf (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .usb_addr_i  (usb_addr_i),    .usb_data_i    (usb_data_i),
      .usb_alen_n_i(usb_alen_n_i),  .usb_cen_n_i   (usb_cen_n_i),
      .usb_wrn_n_i (usb_wrn_n_i),   .usb_rdn_n_i   (usb_rdn_n_i),
      .reg_rdata_i (reg_rdata),     .fifo_byte_i   (fifo_byte),
      .usb_data_o  (usb_data_o),    .usb_data_oe_o (usb_data_oe_o),
      .reg_addr_o  (reg_addr),      .reg_wdata_o   (reg_wdata),
      .reg_write_o (reg_write),     .fifo_rd_o     (fifo_rd)
   );

   ctrl_regs u_ctrl_regs (
      .clk_usb_buf (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .reg_addr_i  (reg_addr),      .reg_wdata_i   (reg_wdata),
      .reg_write_i (reg_write),     .cap_done_i    (cap_done),
      .cap_active_i(cap_active),    .fifo_empty_i  (fifo_empty),
      .fifo_full_i (fifo_full),     .ovf_err_i     (ovf_err),
      .reg_rdata_o (reg_rdata),     .arm_o         (arm),
      .src_sel_o   (src_sel),       .length_o      (length),
      .clr_err_o   (clr_err),       .flush_o       (flush)
   );

   capture_select u_capture_select (
      .clk_usb_buf  (clk_usb_buf),  .arst_n_i      (arst_n_i),
      .arm_i        (arm),          .src_sel_i     (src_sel),
      .length_i     (length),
      .trace_data_i (trace_data_i), .trace_valid_i (trace_valid_i),
      .la_data_i    (la_data_i),    .la_valid_i    (la_valid_i),
      .wr_en_o      (wr_en),        .wr_word_o     (wr_word),
      .cap_done_o   (cap_done),     .cap_active_o  (cap_active)
   );

   capture_fifo #(
      .pFIFO_DEPTH (pFIFO_DEPTH)
   ) u_capture_fifo (
      .clk_usb_buf (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .wr_en_i     (wr_en),         .wr_word_i     (wr_word),
      .pop_i       (pop),           .flush_i       (flush),
      .clr_err_i   (clr_err),       .rd_word_o     (rd_word),
      .empty_o     (fifo_empty),    .full_o        (fifo_full),
      .ovf_err_o   (ovf_err)
   );

   fifo_byte_reader u_fifo_byte_reader (
      .clk_usb_buf (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .fifo_rd_i   (fifo_rd),       .flush_i       (flush),
      .rd_word_i   (rd_word),       .empty_i       (fifo_empty),
      .fifo_byte_o (fifo_byte),     .pop_o         (pop)
   );

   led_status #(
      .pFLASH_BITS (pFLASH_BITS)
   ) u_led_status (
      .clk_usb_buf (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .err_i       (ovf_err),       .active_i      (cap_active),
      .arm_i       (arm),           .led_error_o   (led_error_o),
      .led_capture_o(led_capture_o), .led_armed_o  (led_armed_o)
   );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
   parameter int pHALF_PERIOD  = 5,
   parameter int pRESET_CYCLES = 4
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(pHALF_PERIOD) clk_o = ~clk_o;  // 10 ns period
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (pRESET_CYCLES) @(posedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

// File: tb/capture_usb_tb.sv
`timescale 1ns/100ps

module capture_usb_tb import capture_pkg::*; ();

   localparam int FIFO_DEPTH = 16;
   localparam int FLASH_BITS = 4;
   localparam int SEED       = 11185;
   localparam int WORD_W     = TAG_W + DATA_W;

   localparam logic [7:0] ST_EMPTY = 8'(1 << STAT_EMPTY_BIT);
   localparam logic [7:0] ST_FULL  = 8'(1 << STAT_FULL_BIT);
   localparam logic [7:0] ST_OVF   = 8'(1 << STAT_OVF_BIT);

   logic              clk_usb_buf;
   logic              arst_n_i;
   logic [7:0]        usb_addr_i;
   logic [7:0]        usb_data_i;
   logic [7:0]        usb_data_o;
   logic              usb_data_oe_o;
   logic              usb_alen_n_i;
   logic              usb_cen_n_i;
   logic              usb_wrn_n_i;
   logic              usb_rdn_n_i;
   logic [DATA_W-1:0] trace_data_i;
   logic              trace_valid_i;
   logic [DATA_W-1:0] la_data_i;
   logic              la_valid_i;
   logic              led_error_o;
   logic              led_capture_o;
   logic              led_armed_o;

   // Stimulus control and reference model state
   logic              stim_en;
   logic              valid_all;
   logic              model_armed;
   logic              model_src;
   int                model_len;
   int                model_count;
   logic [WORD_W-1:0] model_q[$];

   tb_clkgen #(
      .pHALF_PERIOD  (5),
      .pRESET_CYCLES (4)
   ) u_clkgen (
      .clk_o    (clk_usb_buf),
      .arst_n_o (arst_n_i)
   );

   capture_usb_top #(
      .pFIFO_DEPTH (FIFO_DEPTH),
      .pFLASH_BITS (FLASH_BITS)
   ) UUT (
      .clk_usb_buf   (clk_usb_buf),   .arst_n_i      (arst_n_i),
      .usb_addr_i    (usb_addr_i),    .usb_data_i    (usb_data_i),
      .usb_data_o    (usb_data_o),    .usb_data_oe_o (usb_data_oe_o),
      .usb_alen_n_i  (usb_alen_n_i),  .usb_cen_n_i   (usb_cen_n_i),
      .usb_wrn_n_i   (usb_wrn_n_i),   .usb_rdn_n_i   (usb_rdn_n_i),
      .trace_data_i  (trace_data_i),  .trace_valid_i (trace_valid_i),
      .la_data_i     (la_data_i),     .la_valid_i    (la_valid_i),
      .led_error_o   (led_error_o),   .led_capture_o (led_capture_o),
      .led_armed_o   (led_armed_o)
   );

   // Model of the capture rule, same sampling edge as the DUT
   always @(posedge clk_usb_buf) begin
      if (model_armed && model_count < model_len) begin
         if (model_src ? la_valid_i : trace_valid_i) begin
            if (model_q.size() < FIFO_DEPTH)  // Dropped past the depth but still counted
               model_q.push_back(model_src ? {TAG_LA, la_data_i} : {TAG_TRACE, trace_data_i});
            model_count = model_count + 1;
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s got=0x%0h exp=0x%0h", name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   function automatic logic [7:0] word_byte(input logic [WORD_W-1:0] w, input int idx);
      case (idx)
         0:       return w[7:0];
         1:       return w[15:8];
         default: return {{(8-TAG_W){1'b0}}, w[WORD_W-1 -: TAG_W]};
      endcase
   endfunction

   // New source data every cycle, valid only while enabled
   task automatic drive_sources();
      forever begin
         @(posedge clk_usb_buf);
         trace_data_i  <= 16'($urandom);
         la_data_i     <= 16'($urandom);
         trace_valid_i <= stim_en & (valid_all | 1'($urandom_range(1, 0)));
         la_valid_i    <= stim_en & (valid_all | 1'($urandom_range(1, 0)));
      end
   endtask

   task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_alen_n_i <= 1'b0;
      usb_addr_i   <= addr;
      @(posedge clk_usb_buf);
      usb_alen_n_i <= 1'b1;
      usb_data_i   <= data;
      usb_cen_n_i  <= 1'b0;
      usb_wrn_n_i  <= 1'b0;
      @(posedge clk_usb_buf);
      usb_cen_n_i  <= 1'b1;
      usb_wrn_n_i  <= 1'b1;
      repeat (3) @(posedge clk_usb_buf);  // Register update has landed
   endtask

   task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_alen_n_i <= 1'b0;
      usb_addr_i   <= addr;
      @(posedge clk_usb_buf);
      usb_alen_n_i <= 1'b1;
      usb_cen_n_i  <= 1'b0;
      usb_rdn_n_i  <= 1'b0;
      @(posedge clk_usb_buf);
      check_value("usb_data_oe_o", usb_data_oe_o, 1);
      repeat (2) @(posedge clk_usb_buf);
      data = usb_data_o;  // Third edge after the strobe
      usb_cen_n_i <= 1'b1;
      usb_rdn_n_i <= 1'b1;
      @(posedge clk_usb_buf);
   endtask

   task automatic check_status(input logic [7:0] exp);
      logic [7:0] b;
      host_read(REG_STATUS_ADDR, b);
      check_value("status", b, exp);
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (!arst_n_i) begin
         @(posedge clk_usb_buf);
         cycles++;
         if (cycles > 20)
            report_timeout("reset was never released");
      end
      @(posedge clk_usb_buf);
   endtask

   task automatic wait_disarm();
      int cycles;
      cycles = 0;
      while (led_armed_o) begin
         @(posedge clk_usb_buf);
         cycles++;
         if (cycles > 1000)
            report_timeout("capture never finished");
      end
   endtask

   // Arm with quiet sources, then let data flow until the DUT disarms
   task automatic run_capture(input logic src, input int len, input logic all_valid);
      logic [7:0] ctrl;
      stim_en   = 1'b0;
      valid_all = all_valid;
      repeat (2) @(posedge clk_usb_buf);
      model_src   = src;
      model_len   = len;
      model_count = 0;
      model_armed = 1'b1;
      host_write(REG_LENGTH_ADDR, 8'(len));
      ctrl               = '0;
      ctrl[CTRL_ARM_BIT] = 1'b1;
      ctrl[CTRL_SRC_BIT] = src;
      host_write(REG_CTRL_ADDR, ctrl);
      check_value("led_armed_o", led_armed_o, 1);
      check_value("led_capture_o", led_capture_o, 1);
      stim_en = 1'b1;
      wait_disarm();
      stim_en = 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      model_armed = 1'b0;
      check_value("capture count", model_count, len);
      check_value("led_capture_o", led_capture_o, 0);
   endtask

   task automatic drain_words();
      logic [WORD_W-1:0] w;
      logic [7:0]        b;
      while (model_q.size() > 0) begin
         w = model_q.pop_front();
         for (int i = 0; i < 3; i++) begin
            host_read(FIFO_READ_ADDR, b);
            check_value("usb_data_o", b, word_byte(w, i));
         end
      end
   endtask

   initial begin
      logic [7:0]  b;
      logic [7:0]  len_val;
      logic [7:0]  ctrl;
      logic        seen_hi;
      logic        seen_lo;
      int          cycles;

      void'($urandom(SEED));
      usb_addr_i    <= '0;
      usb_data_i    <= '0;
      usb_alen_n_i  <= 1'b1;
      usb_cen_n_i   <= 1'b1;
      usb_wrn_n_i   <= 1'b1;
      usb_rdn_n_i   <= 1'b1;
      trace_data_i  <= '0;
      trace_valid_i <= 1'b0;
      la_data_i     <= '0;
      la_valid_i    <= 1'b0;
      stim_en     = 1'b0;
      valid_all   = 1'b0;
      model_armed = 1'b0;
      model_src   = 1'b0;
      model_len   = 0;
      model_count = 0;
      fork
         drive_sources();
      join_none

      wait_reset_release();

      // Idle state and register read-back
      check_value("usb_data_oe_o", usb_data_oe_o, 0);
      check_value("led_error_o", led_error_o, 0);
      check_value("led_capture_o", led_capture_o, 0);
      check_value("led_armed_o", led_armed_o, 0);
      check_status(ST_EMPTY);
      len_val = 8'($urandom);
      host_write(REG_LENGTH_ADDR, len_val);
      host_read(REG_LENGTH_ADDR, b);
      check_value("length", b, len_val);
      ctrl               = '0;
      ctrl[CTRL_SRC_BIT] = 1'b1;
      host_write(REG_CTRL_ADDR, ctrl);
      host_read(REG_CTRL_ADDR, b);
      check_value("ctrl", b, ctrl);
      host_write(REG_CTRL_ADDR, 8'h00);

      // Trace then LA capture with random valids
      run_capture(1'b0, $urandom_range(10, 1), 1'b0);
      drain_words();
      check_status(ST_EMPTY);
      run_capture(1'b1, $urandom_range(10, 1), 1'b0);
      drain_words();
      check_status(ST_EMPTY);

      // Overflow
      run_capture(1'b0, 20, 1'b1);
      check_status(ST_FULL | ST_OVF);
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      for (int i = 0; i < 64; i++) begin
         @(posedge clk_usb_buf);
         if (led_error_o)
            seen_hi = 1'b1;
         else
            seen_lo = 1'b1;
      end
      if (!(seen_hi && seen_lo))
         report_timeout("led_error_o did not flash within 64 cycles");
      drain_words();
      check_status(ST_EMPTY | ST_OVF);
      ctrl                   = '0;
      ctrl[CTRL_CLR_ERR_BIT] = 1'b1;
      host_write(REG_CTRL_ADDR, ctrl);
      check_status(ST_EMPTY);
      cycles = 0;
      while (led_error_o) begin
         @(posedge clk_usb_buf);
         cycles++;
         if (cycles > 8)
            report_timeout("led_error_o stayed on after clearing the error");
      end
      repeat (32) begin
         @(posedge clk_usb_buf);
         check_value("led_error_o", led_error_o, 0);
      end

      // Flush after a partial read
      run_capture(1'b1, 6, 1'b1);
      host_read(FIFO_READ_ADDR, b);
      check_value("usb_data_o", b, word_byte(model_q[0], 0));
      ctrl                 = '0;
      ctrl[CTRL_FLUSH_BIT] = 1'b1;
      host_write(REG_CTRL_ADDR, ctrl);
      model_q.delete();
      check_status(ST_EMPTY);
      host_read(FIFO_READ_ADDR, b);
      check_value("usb_data_o", b, 0);

      // Empty reads do not move the byte index
      host_read(FIFO_READ_ADDR, b);
      check_value("usb_data_o", b, 0);
      check_status(ST_EMPTY);
      run_capture(1'($urandom_range(1, 0)), 3, 1'b0);
      drain_words();
      check_status(ST_EMPTY);

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: capture_usb_top.f
src/capture_pkg.sv
src/usb_reg_port.sv
src/ctrl_regs.sv
src/capture_select.sv
src/capture_fifo.sv
src/fifo_byte_reader.sv
src/led_status.sv
src/capture_usb_top.sv
tb/tb_clkgen.sv
tb/capture_usb_tb.sv
